/* rtl/bp_pkg.sv */
package bp_pkg;

   // Address widths
   localparam int PC_W = 32;

   // Branch target buffer geometry
   localparam int BTB_IDX_W   = 5;
   localparam int BTB_ENTRIES = 1 << BTB_IDX_W;
   localparam int BTB_TAG_W   = PC_W - BTB_IDX_W;

   // Gshare history table geometry
   localparam int BHT_IDX_W   = 5;
   localparam int BHT_ENTRIES = 1 << BHT_IDX_W;
   localparam int BHT_TAG_W   = PC_W - BHT_IDX_W;

   // History is XORed straight into the table index
   localparam int GHR_W = BHT_IDX_W;

   // Fetch address generation
   localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;
   localparam logic [PC_W-1:0] PC_STEP  = 32'd4;

   // 2-bit saturating counter states
   typedef enum logic [1:0] {
      CTR_STRONG_NT = 2'd0,
      CTR_WEAK_NT   = 2'd1,
      CTR_WEAK_T    = 2'd2,
      CTR_STRONG_T  = 2'd3
   } bp_ctr_e;

   // Statistics counters
   localparam int CNT_W = 32;

   // APB register map
   localparam int APB_ADDR_W = 4;
   localparam logic [APB_ADDR_W-1:0] STAT_CORRECT_ADDR = 4'h0;
   localparam logic [APB_ADDR_W-1:0] STAT_WRONG_ADDR   = 4'h4;
   localparam logic [APB_ADDR_W-1:0] STAT_CLEAR_ADDR   = 4'h8;

endpackage

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen import bp_pkg::*; (
   input  logic            clk_i,
   input  logic            rstn_i,

   input  logic            fetch_en_i,

   input  logic            pred_taken_i,
   input  logic [PC_W-1:0] pred_target_i,

   input  logic            redirect_valid_i,
   input  logic [PC_W-1:0] redirect_pc_i,

   output logic [PC_W-1:0] fetch_pc_o,
   output logic            fetch_valid_o
);

   logic [PC_W-1:0] pc_q;
   logic            run_q; // Set once the core is out of reset

   // Valid follows the enable only after reset has been released
   assign fetch_valid_o = fetch_en_i && run_q;
   assign fetch_pc_o    = pc_q;

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         run_q <= 1'b0;
      end else begin
         run_q <= 1'b1;
      end
   end

   // Priority: redirect, stall, predicted target, sequential
   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         pc_q <= RESET_PC;
      end else if (redirect_valid_i) begin
         pc_q <= redirect_pc_i; // Wins even while stalled
      end else if (!fetch_valid_o) begin
         pc_q <= pc_q; // Back-pressure
      end else if (pred_taken_i) begin
         pc_q <= pred_target_i;
      end else begin
         pc_q <= pc_q + PC_STEP;
      end
   end

endmodule

/* rtl/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import bp_pkg::*; (
   input  logic            clk_i,
   input  logic            rstn_i,

   input  logic [PC_W-1:0] fetch_pc_i,
   input  logic            fetch_valid_i,
   output logic            pred_taken_o,
   output logic [PC_W-1:0] pred_target_o,

   input  logic            upd_valid_i,
   input  logic [PC_W-1:0] upd_pc_i,
   input  logic            upd_taken_i,
   input  logic [PC_W-1:0] upd_target_i
);

   // BTB storage, one valid, tag and target per entry
   logic                 btb_valid_q [BTB_ENTRIES];
   logic [BTB_TAG_W-1:0] btb_tag_q   [BTB_ENTRIES];
   logic [PC_W-1:0]      btb_tgt_q   [BTB_ENTRIES];

   // Tagged gshare table
   logic [BHT_TAG_W-1:0] bht_tag_q   [BHT_ENTRIES];
   bp_ctr_e              bht_ctr_q   [BHT_ENTRIES];

   logic [GHR_W-1:0]     ghr_q; // Newest outcome in bit 0

   logic [BTB_IDX_W-1:0] fetch_btb_idx;
   logic [BHT_IDX_W-1:0] fetch_bht_idx;
   logic [BTB_IDX_W-1:0] upd_btb_idx;
   logic [BHT_IDX_W-1:0] upd_bht_idx;
   logic                 btb_hit;
   logic                 bht_hit;
   logic                 ctr_taken;
   bp_ctr_e              upd_ctr_old;
   bp_ctr_e              upd_ctr_new;

   // Lookup side
   assign fetch_btb_idx = fetch_pc_i[BTB_IDX_W-1:0];
   assign fetch_bht_idx = fetch_pc_i[BHT_IDX_W-1:0] ^ ghr_q; // Gshare hash

   assign btb_hit = btb_valid_q[fetch_btb_idx] &&
                    (btb_tag_q[fetch_btb_idx] == fetch_pc_i[PC_W-1:BTB_IDX_W]);
   assign bht_hit = (bht_tag_q[fetch_bht_idx] == fetch_pc_i[PC_W-1:BHT_IDX_W]);

   assign ctr_taken = (bht_ctr_q[fetch_bht_idx] == CTR_WEAK_T) ||
                      (bht_ctr_q[fetch_bht_idx] == CTR_STRONG_T);

   assign pred_target_o = btb_tgt_q[fetch_btb_idx];

   // A zero target never counts as a usable prediction
   assign pred_taken_o = fetch_valid_i && btb_hit && bht_hit && ctr_taken &&
                         (pred_target_o != '0);

   // Training side, indexed with the history before the shift
   assign upd_btb_idx = upd_pc_i[BTB_IDX_W-1:0];
   assign upd_bht_idx = upd_pc_i[BHT_IDX_W-1:0] ^ ghr_q;
   assign upd_ctr_old = bht_ctr_q[upd_bht_idx];

   always_comb begin
      upd_ctr_new = upd_ctr_old;
      case (upd_ctr_old)
         CTR_STRONG_NT: begin
            upd_ctr_new = upd_taken_i ? CTR_WEAK_NT : CTR_STRONG_NT;
         end
         CTR_WEAK_NT: begin
            upd_ctr_new = upd_taken_i ? CTR_WEAK_T : CTR_STRONG_NT;
         end
         CTR_WEAK_T: begin
            upd_ctr_new = upd_taken_i ? CTR_STRONG_T : CTR_WEAK_NT;
         end
         CTR_STRONG_T: begin
            upd_ctr_new = upd_taken_i ? CTR_STRONG_T : CTR_WEAK_T;
         end
         default: begin
            upd_ctr_new = CTR_STRONG_NT;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         for (int i = 0; i < BTB_ENTRIES; i++) begin
            btb_valid_q[i] <= 1'b0;
            btb_tag_q[i]   <= '0;
            btb_tgt_q[i]   <= '0;
         end
         for (int j = 0; j < BHT_ENTRIES; j++) begin
            bht_tag_q[j] <= '0;
            bht_ctr_q[j] <= CTR_STRONG_NT;
         end
         ghr_q <= '0;
      end else if (upd_valid_i) begin
         bht_tag_q[upd_bht_idx] <= upd_pc_i[PC_W-1:BHT_IDX_W];
         bht_ctr_q[upd_bht_idx] <= upd_ctr_new;
         if (upd_taken_i) begin // Only taken branches allocate a BTB entry
            btb_valid_q[upd_btb_idx] <= 1'b1;
            btb_tag_q[upd_btb_idx]   <= upd_pc_i[PC_W-1:BTB_IDX_W];
            btb_tgt_q[upd_btb_idx]   <= upd_target_i;
         end
         ghr_q <= {ghr_q[GHR_W-2:0], upd_taken_i};
      end
   end

endmodule

/* rtl/branch_resolver.sv */
`timescale 1ns/1ps

module branch_resolver import bp_pkg::*; (
   // Executed branch report
   input  logic            ex_valid_i,
   input  logic [PC_W-1:0] ex_pc_i,
   input  logic            ex_taken_i,
   input  logic [PC_W-1:0] ex_target_i,
   input  logic            ex_pred_taken_i,
   input  logic [PC_W-1:0] ex_pred_target_i,

   // Predictor training
   output logic            upd_valid_o,
   output logic [PC_W-1:0] upd_pc_o,
   output logic            upd_taken_o,
   output logic [PC_W-1:0] upd_target_o,

   // Fetch redirect
   output logic            redirect_valid_o,
   output logic [PC_W-1:0] redirect_pc_o,

   // Statistics
   output logic            stat_valid_o,
   output logic            stat_wrong_o
);

   logic dir_wrong;
   logic tgt_wrong;
   logic mispredict;

   // Direction disagrees
   assign dir_wrong = (ex_pred_taken_i != ex_taken_i);

   // Both taken but to different places
   assign tgt_wrong = ex_pred_taken_i && ex_taken_i && (ex_pred_target_i != ex_target_i);

   assign mispredict = dir_wrong || tgt_wrong;

   // Correct path for the fetch unit
   always_comb begin
      if (ex_taken_i) begin
         redirect_pc_o = ex_target_i;
      end else begin
         redirect_pc_o = ex_pc_i + PC_STEP; // Fall-through
      end
   end

   assign redirect_valid_o = ex_valid_i && mispredict;

   // Every resolved branch trains the predictor
   assign upd_valid_o  = ex_valid_i;
   assign upd_pc_o     = ex_pc_i;
   assign upd_taken_o  = ex_taken_i;
   assign upd_target_o = ex_target_i;

   assign stat_valid_o = ex_valid_i;
   assign stat_wrong_o = mispredict;

endmodule

/* rtl/bp_stats_apb.sv */
`timescale 1ns/1ps

module bp_stats_apb import bp_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rstn_i,

   input  logic                  stat_valid_i,
   input  logic                  stat_wrong_i,

   // APB3 slave
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [CNT_W-1:0]      pwdata_i,
   output logic [CNT_W-1:0]      prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o
);

   logic [CNT_W-1:0] correct_q;
   logic [CNT_W-1:0] wrong_q;
   logic [CNT_W-1:0] rdata;
   logic             dec_err;
   logic             access;
   logic             clear;

   assign access = psel_i && penable_i;

   // Address decode
   always_comb begin
      rdata   = '0;
      dec_err = 1'b0;
      case (paddr_i)
         STAT_CORRECT_ADDR: begin
            rdata   = correct_q;
            dec_err = pwrite_i; // Counters are read-only
         end
         STAT_WRONG_ADDR: begin
            rdata   = wrong_q;
            dec_err = pwrite_i;
         end
         STAT_CLEAR_ADDR: begin
            rdata = '0; // Clear register reads as zero
         end
         default: begin
            dec_err = 1'b1;
         end
      endcase
   end

   assign pready_o  = psel_i; // No wait states
   assign pslverr_o = access && dec_err;
   assign prdata_o  = (psel_i && !pwrite_i) ? rdata : '0;

   assign clear = access && pwrite_i && (paddr_i == STAT_CLEAR_ADDR) && pwdata_i[0];

   always_ff @(posedge clk_i) begin
      if (!rstn_i) begin
         correct_q <= '0;
         wrong_q   <= '0;
      end else if (clear) begin
         correct_q <= '0; // Clear beats a same-cycle resolution
         wrong_q   <= '0;
      end else if (stat_valid_i) begin
         if (stat_wrong_i) begin
            wrong_q <= wrong_q + 1'b1;
         end else begin
            correct_q <= correct_q + 1'b1;
         end
      end
   end

endmodule

/* rtl/bp_frontend_top.sv */
`timescale 1ns/1ps

module bp_frontend_top import bp_pkg::*; (
   input  logic                  clk_i,
   input  logic                  rstn_i,

   // Fetch side
   input  logic                  fetch_en_i,
   output logic [PC_W-1:0]       fetch_pc_o,
   output logic                  fetch_valid_o,
   output logic                  pred_taken_o,
   output logic [PC_W-1:0]       pred_target_o,

   // Executed branch report
   input  logic                  ex_valid_i,
   input  logic [PC_W-1:0]       ex_pc_i,
   input  logic                  ex_taken_i,
   input  logic [PC_W-1:0]       ex_target_i,
   input  logic                  ex_pred_taken_i,
   input  logic [PC_W-1:0]       ex_pred_target_i,

   // APB statistics port
   input  logic [APB_ADDR_W-1:0] paddr_i,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  logic [CNT_W-1:0]      pwdata_i,
   output logic [CNT_W-1:0]      prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o
);

   logic            upd_valid;
   logic [PC_W-1:0] upd_pc;
   logic            upd_taken;
   logic [PC_W-1:0] upd_target;
   logic            redirect_valid;
   logic [PC_W-1:0] redirect_pc;
   logic            stat_valid;
   logic            stat_wrong;

   fetch_pc_gen fetch_pc_gen_inst (
      .clk_i            (clk_i),
      .rstn_i           (rstn_i),
      .fetch_en_i       (fetch_en_i),
      .pred_taken_i     (pred_taken_o),
      .pred_target_i    (pred_target_o),
      .redirect_valid_i (redirect_valid),
      .redirect_pc_i    (redirect_pc),
      .fetch_pc_o       (fetch_pc_o),
      .fetch_valid_o    (fetch_valid_o)
   );

   branch_predictor branch_predictor_inst (
      .clk_i         (clk_i),
      .rstn_i        (rstn_i),
      .fetch_pc_i    (fetch_pc_o),
      .fetch_valid_i (fetch_valid_o),
      .pred_taken_o  (pred_taken_o),
      .pred_target_o (pred_target_o),
      .upd_valid_i   (upd_valid),
      .upd_pc_i      (upd_pc),
      .upd_taken_i   (upd_taken),
      .upd_target_i  (upd_target)
   );

   branch_resolver branch_resolver_inst (
      .ex_valid_i       (ex_valid_i),
      .ex_pc_i          (ex_pc_i),
      .ex_taken_i       (ex_taken_i),
      .ex_target_i      (ex_target_i),
      .ex_pred_taken_i  (ex_pred_taken_i),
      .ex_pred_target_i (ex_pred_target_i),
      .upd_valid_o      (upd_valid),
      .upd_pc_o         (upd_pc),
      .upd_taken_o      (upd_taken),
      .upd_target_o     (upd_target),
      .redirect_valid_o (redirect_valid),
      .redirect_pc_o    (redirect_pc),
      .stat_valid_o     (stat_valid),
      .stat_wrong_o     (stat_wrong)
   );

   bp_stats_apb bp_stats_apb_inst (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .stat_valid_i (stat_valid),
      .stat_wrong_i (stat_wrong),
      .paddr_i      (paddr_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o)
   );

endmodule

/* testbench/tb_bp_model.svh */
logic                 m_btb_valid [BTB_ENTRIES];
logic [BTB_TAG_W-1:0] m_btb_tag   [BTB_ENTRIES];
logic [PC_W-1:0]      m_btb_tgt   [BTB_ENTRIES];
logic [BHT_TAG_W-1:0] m_bht_tag   [BHT_ENTRIES];
logic [1:0]           m_bht_ctr   [BHT_ENTRIES]; // 0 strong not-taken .. 3 strong taken
logic [GHR_W-1:0]     m_ghr;
logic [PC_W-1:0]      m_pc;
logic                 m_run;                     // Set after the first edge out of reset
logic [CNT_W-1:0]     m_correct;
logic [CNT_W-1:0]     m_wrong;

function automatic void model_reset();
   for (int i = 0; i < BTB_ENTRIES; i++) begin
      m_btb_valid[i] = 1'b0;
      m_btb_tag[i]   = '0;
      m_btb_tgt[i]   = '0;
   end
   for (int i = 0; i < BHT_ENTRIES; i++) begin
      m_bht_tag[i] = '0;
      m_bht_ctr[i] = 2'd0;
   end
   m_ghr     = '0;
   m_pc      = RESET_PC;
   m_run     = 1'b0;
   m_correct = '0;
   m_wrong   = '0;
endfunction

function automatic logic model_pred_taken(input logic [PC_W-1:0] pc, input logic valid);
   logic [BTB_IDX_W-1:0] bi;
   logic [BHT_IDX_W-1:0] hi;
   bi = pc[BTB_IDX_W-1:0];
   hi = pc[BHT_IDX_W-1:0] ^ m_ghr;
   return valid && m_btb_valid[bi] && (m_btb_tag[bi] == pc[PC_W-1:BTB_IDX_W]) &&
          (m_bht_tag[hi] == pc[PC_W-1:BHT_IDX_W]) && (m_bht_ctr[hi] >= 2'd2) &&
          (m_btb_tgt[bi] != '0);
endfunction

function automatic logic [PC_W-1:0] model_pred_target(input logic [PC_W-1:0] pc);
   return m_btb_tgt[pc[BTB_IDX_W-1:0]];
endfunction

// Fetch choice and counting see the tables before this edge's training
function automatic void model_clock(input logic en, input logic exv, input logic [PC_W-1:0] expc,
                                    input logic ext, input logic [PC_W-1:0] extgt,
                                    input logic exptk, input logic [PC_W-1:0] exptgt,
                                    input logic clr);
   logic                 mis;
   logic [PC_W-1:0]      next_pc;
   logic [BHT_IDX_W-1:0] hi;
   logic [BTB_IDX_W-1:0] bi;
   mis = (exptk != ext) || (exptk && ext && (exptgt != extgt));
   if (exv && mis)
      next_pc = ext ? extgt : expc + PC_STEP;
   else if (!(en && m_run))
      next_pc = m_pc;                            // Stall
   else if (model_pred_taken(m_pc, 1'b1))
      next_pc = model_pred_target(m_pc);
   else
      next_pc = m_pc + PC_STEP;
   if (clr) begin
      m_correct = '0;
      m_wrong   = '0;
   end else if (exv) begin
      if (mis)
         m_wrong = m_wrong + 1;
      else
         m_correct = m_correct + 1;
   end
   if (exv) begin
      hi = expc[BHT_IDX_W-1:0] ^ m_ghr;
      bi = expc[BTB_IDX_W-1:0];
      m_bht_tag[hi] = expc[PC_W-1:BHT_IDX_W];
      if (ext && m_bht_ctr[hi] != 2'd3)
         m_bht_ctr[hi] = m_bht_ctr[hi] + 2'd1;
      else if (!ext && m_bht_ctr[hi] != 2'd0)
         m_bht_ctr[hi] = m_bht_ctr[hi] - 2'd1;
      if (ext) begin
         m_btb_valid[bi] = 1'b1;
         m_btb_tag[bi]   = expc[PC_W-1:BTB_IDX_W];
         m_btb_tgt[bi]   = extgt;
      end
      m_ghr = {m_ghr[GHR_W-2:0], ext};
   end
   m_pc  = next_pc;
   m_run = 1'b1;
endfunction

/* testbench/tb_bp_frontend.sv */
`timescale 1ns/1ps

module tb_bp_frontend import bp_pkg::*; ();

   localparam int CLK_PERIOD  = 10;
   localparam int TEST_CYCLES = 2500;  // Upper bound on the length of all tests
   localparam int MARGIN_NS   = 2000;

   logic clk_i = 1'b0;
   logic rstn_i, fetch_en_i, fetch_valid_o, pred_taken_o;
   logic [PC_W-1:0] fetch_pc_o, pred_target_o, ex_pc_i, ex_target_i, ex_pred_target_i;
   logic ex_valid_i, ex_taken_i, ex_pred_taken_i;
   logic [APB_ADDR_W-1:0] paddr_i;
   logic psel_i, penable_i, pwrite_i, pready_o, pslverr_o;
   logic [CNT_W-1:0] pwdata_i, prdata_o, rd_sample;
   logic err_sample;
   logic [PC_W-1:0] pc_hold;
   int test_errors = 0;
   int tests_passed = 0;
   int tests_failed = 0;

   // Branch PCs alias on index bits 4..0 so tags conflict
   logic [PC_W-1:0] pc_pool [6] = '{32'h0000_2048, 32'h0000_4048, 32'h0000_2064,
                                    32'h0000_3068, 32'h0000_1008, 32'h0000_5008};
   logic [PC_W-1:0] tgt_pool [8] = '{32'h0000_2048, 32'h0000_4048, 32'h0000_2064,
                                     32'h0000_3068, 32'h0000_1008, 32'h0000_5008,
                                     32'h0000_0000, RESET_PC};

   `include "tb_bp_model.svh"

   bp_frontend_top bp_frontend_top_inst (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      if (test_errors == 0) begin
         tests_passed++;
         $display("Test %s: done, no mismatches", name);
      end else begin
         tests_failed++;
         $display("Test %s: done, %0d mismatches", name, test_errors);
      end
      test_errors = 0;
   endtask

   // Entered 1 ns after an edge to compare mid-cycle and clock the model
   task automatic tick();
      logic clr;
      #4;
      check_value("fetch_pc_o", fetch_pc_o, m_pc);
      check_value("fetch_valid_o", fetch_valid_o, fetch_en_i && m_run);
      check_value("pred_taken_o", pred_taken_o, model_pred_taken(m_pc, fetch_en_i && m_run));
      check_value("pred_target_o", pred_target_o, model_pred_target(m_pc));
      check_value("pready_o", pready_o, psel_i);
      rd_sample  = prdata_o;
      err_sample = pslverr_o;
      clr = psel_i && penable_i && pwrite_i && (paddr_i == STAT_CLEAR_ADDR) && pwdata_i[0];
      @(posedge clk_i);
      model_clock(fetch_en_i, ex_valid_i, ex_pc_i, ex_taken_i, ex_target_i,
                  ex_pred_taken_i, ex_pred_target_i, clr);
      #1;
   endtask

   task automatic report_branch(input logic [PC_W-1:0] pc, input logic taken,
                                input logic [PC_W-1:0] tgt, input logic ptaken,
                                input logic [PC_W-1:0] ptgt);
      ex_pc_i          = pc;
      ex_taken_i       = taken;
      ex_target_i      = tgt;
      ex_pred_taken_i  = ptaken;
      ex_pred_target_i = ptgt;
      ex_valid_i       = 1'b1;
      tick();
      ex_valid_i = 1'b0;
   endtask

   task automatic apb_access(input logic [APB_ADDR_W-1:0] addr, input logic wr,
                             input logic [CNT_W-1:0] wdata, input logic [CNT_W-1:0] exp,
                             input logic exp_err);
      paddr_i   = addr;
      pwrite_i  = wr;
      pwdata_i  = wdata;
      psel_i    = 1'b1;
      penable_i = 1'b0;
      tick();                          // Setup phase
      penable_i = 1'b1;
      tick();                          // Access phase
      if (!wr)
         check_value("prdata_o", rd_sample, exp);
      check_value("pslverr_o", err_sample, exp_err);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic random_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         fetch_en_i  = ($urandom % 4) != 0;
         ex_valid_i  = ($urandom % 3) == 0;
         ex_pc_i     = pc_pool[$urandom % 6];
         ex_taken_i  = $urandom % 2;
         ex_target_i = tgt_pool[$urandom % 8];
         if ($urandom % 2) begin       // Report carries what the predictor said
            ex_pred_taken_i  = model_pred_taken(ex_pc_i, 1'b1);
            ex_pred_target_i = model_pred_target(ex_pc_i);
         end else begin
            ex_pred_taken_i  = $urandom % 2;
            ex_pred_target_i = tgt_pool[$urandom % 8];
         end
         tick();
      end
      ex_valid_i = 1'b0;
   endtask

   initial begin
      #(TEST_CYCLES * CLK_PERIOD + MARGIN_NS);
      $display("Timeout: the tests did not finish within %0d ns", TEST_CYCLES * CLK_PERIOD);
      $display("** FAIL **");
      $finish;
   end

   initial begin
      rd_sample = $urandom(32'h91d52582);
      {rstn_i, fetch_en_i, ex_valid_i, ex_taken_i, ex_pred_taken_i} = '0;
      {ex_pc_i, ex_target_i, ex_pred_target_i} = '0;
      {paddr_i, psel_i, penable_i, pwrite_i, pwdata_i} = '0;
      repeat (2) @(posedge clk_i);
      #1 rstn_i = 1'b1;
      model_reset();

      check_value("fetch_pc_o after reset", fetch_pc_o, RESET_PC);
      tick();
      apb_access(STAT_CORRECT_ADDR, 1'b0, '0, '0, 1'b0);
      apb_access(STAT_WRONG_ADDR, 1'b0, '0, '0, 1'b0);
      finish_test("reset");

      fetch_en_i = 1'b1;
      repeat (6) tick();
      pc_hold    = fetch_pc_o;
      fetch_en_i = 1'b0;
      repeat (3) tick();
      check_value("fetch_pc_o in stall", fetch_pc_o, pc_hold);
      fetch_en_i = 1'b1;
      tick();
      check_value("fetch_pc_o after stall", fetch_pc_o, pc_hold + PC_STEP);
      finish_test("sequential fetch and stall");

      fetch_en_i = 1'b0;
      repeat (8) report_branch(32'h0000_2048, 1'b1, 32'h0000_3010, 1'b1, 32'h0000_3010);
      report_branch(32'h0000_2064, 1'b1, 32'h0000_2048, 1'b0, '0);  // Steer fetch to the branch
      fetch_en_i = 1'b1;
      #1;
      check_value("trained pred_taken_o", pred_taken_o, 1'b1);
      check_value("trained pred_target_o", pred_target_o, 32'h0000_3010);
      tick();
      check_value("fetch_pc_o after taken prediction", fetch_pc_o, 32'h0000_3010);
      fetch_en_i = 1'b0;
      repeat (2) begin                 // Each not-taken report lands on the same history
         report_branch(32'h0000_2048, 1'b0, 32'h0000_3010, 1'b1, 32'h0000_3010);
         repeat (5) report_branch(32'h0000_2064, 1'b1, 32'h0000_2048, 1'b0, '0);
      end
      fetch_en_i = 1'b1;
      #1;
      check_value("untrained pred_taken_o", pred_taken_o, 1'b0);
      tick();
      finish_test("training");

      report_branch(32'h0000_2100, 1'b0, 32'h0000_2200, 1'b1, 32'h0000_2200);
      check_value("redirect to fall-through", fetch_pc_o, 32'h0000_2100 + PC_STEP);
      fetch_en_i = 1'b0;
      report_branch(32'h0000_2100, 1'b1, 32'h0000_2200, 1'b0, '0);
      check_value("redirect in stall", fetch_pc_o, 32'h0000_2200);
      report_branch(32'h0000_2100, 1'b1, 32'h0000_2300, 1'b1, 32'h0000_2200);
      check_value("redirect on wrong target", fetch_pc_o, 32'h0000_2300);
      pc_hold = fetch_pc_o;
      report_branch(32'h0000_2100, 1'b1, 32'h0000_2400, 1'b1, 32'h0000_2400);
      check_value("no redirect when correct", fetch_pc_o, pc_hold);
      finish_test("misprediction redirect");

      random_cycles(300);
      apb_access(STAT_CORRECT_ADDR, 1'b0, '0, m_correct, 1'b0);
      apb_access(STAT_WRONG_ADDR, 1'b0, '0, m_wrong, 1'b0);
      ex_valid_i = 1'b1;               // Resolution alongside the clear
      apb_access(STAT_CLEAR_ADDR, 1'b1, 32'h1, '0, 1'b0);
      ex_valid_i = 1'b0;
      apb_access(STAT_CORRECT_ADDR, 1'b0, '0, '0, 1'b0);
      apb_access(STAT_WRONG_ADDR, 1'b0, '0, '0, 1'b0);
      apb_access(4'hC, 1'b0, '0, '0, 1'b1);
      apb_access(STAT_CORRECT_ADDR, 1'b1, 32'h5, '0, 1'b1);
      apb_access(STAT_WRONG_ADDR, 1'b1, 32'h5, '0, 1'b1);
      apb_access(STAT_CORRECT_ADDR, 1'b0, '0, m_correct, 1'b0);
      apb_access(STAT_WRONG_ADDR, 1'b0, '0, m_wrong, 1'b0);
      finish_test("statistics over APB");

      random_cycles(2000);
      apb_access(STAT_CORRECT_ADDR, 1'b0, '0, m_correct, 1'b0);
      apb_access(STAT_WRONG_ADDR, 1'b0, '0, m_wrong, 1'b0);
      finish_test("random stream");

      $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

/* list.f */
+incdir+testbench
rtl/bp_pkg.sv
rtl/fetch_pc_gen.sv
rtl/branch_predictor.sv
rtl/branch_resolver.sv
rtl/bp_stats_apb.sv
rtl/bp_frontend_top.sv
testbench/tb_bp_frontend.sv

/* Bender.yml */
package:
  name: bp_frontend

sources:
  - files:
      - rtl/bp_pkg.sv
      - rtl/fetch_pc_gen.sv
      - rtl/branch_predictor.sv
      - rtl/branch_resolver.sv
      - rtl/bp_stats_apb.sv
      - rtl/bp_frontend_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_bp_frontend.sv
